//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wall -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
TOP        = tb_uart_frame
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/frame_packer.sv
// message to byte sequencer
// opening "&&", payload bytes in order, closing "&&", each over valid/ready
`timescale 1ns/10ps
`default_nettype none

module frame_packer (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_msg_t tx_msg,
	input  logic                       tx_valid,
	output logic                       tx_ready,
	output logic [7:0]                 tx_byte,
	output logic                       tx_byte_valid,
	input  logic                       tx_byte_ready
);
	import uart_frame_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_open,
		st_payload,
		st_close
	} pk_state_t;

	pk_state_t        state;
	frame_msg_t       msg_q;
	logic [len_w-1:0] idx;
	logic             byte_done;

	// true if any byte inside len is the delimiter
	function automatic logic has_delim(input frame_msg_t m);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < msg_max_bytes; i++) begin
			if (i < m.len && m.data[i] == delim_char)
				hit = 1'b1;
		end
		return hit;
	endfunction

	assign tx_ready      = (state == st_idle);
	assign tx_byte_valid = (state != st_idle);
	assign tx_byte       = (state == st_payload) ? msg_q.data[idx[3:0]] : delim_char;
	assign byte_done     = tx_byte_valid && tx_byte_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_idle;
			idx   <= '0;
		end else begin
			case (state)
				st_idle: if (tx_valid) begin
					state <= st_open;
					idx   <= '0;
				end
				st_open: if (byte_done) begin
					idx <= idx[0] ? '0 : idx + 1'b1;
					if (idx[0])
						state <= st_payload;
				end
				st_payload: if (byte_done) begin
					if (idx == msg_q.len - 1'b1) begin
						idx   <= '0;
						state <= st_close;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: if (byte_done) begin
					idx <= idx[0] ? '0 : idx + 1'b1;
					if (idx[0])
						state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_valid && tx_ready)
			msg_q <= tx_msg;
	end

	a_len_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_valid && tx_ready) |-> (tx_msg.len >= 1 && tx_msg.len <= msg_max_bytes)
	);

	// no escaping, so a delimiter in the payload would end the frame early
	a_no_delim_in_payload: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_valid && tx_ready) |-> !has_delim(tx_msg)
	);

endmodule

`default_nettype wire

//--- rtl/frame_unpacker.sv
// byte stream to message
// hunts for "&&", collects payload until the closing pair, holds the result
// drops on overlength, stop-bit error, stray delimiter or idle timeout
`timescale 1ns/10ps
`default_nettype none

module frame_unpacker (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic [7:0]                 rx_byte,
	input  logic                       rx_byte_valid,
	input  logic                       rx_byte_err,
	input  logic [15:0]                divisor,
	input  logic [15:0]                timeout,
	output uart_frame_pkg::frame_msg_t rx_msg,
	output logic                       rx_valid,
	input  logic                       rx_ready,
	output logic                       frame_ok,
	output logic                       frame_drop
);
	import uart_frame_pkg::*;

	typedef enum logic [1:0] {
		st_hunt,
		st_payload,
		st_hold
	} up_state_t;

	up_state_t        state;
	logic             amp_seen;
	logic [len_w-1:0] cnt;
	logic [15:0]      idle_cyc;
	logic [15:0]      idle_bits;
	logic             bit_tick;
	logic             timed_out;
	logic             is_delim;
	logic             store;

	assign rx_valid  = (state == st_hold);
	assign is_delim  = (rx_byte == delim_char);
	assign bit_tick  = (idle_cyc == divisor - 16'd1);
	assign timed_out = (state == st_payload) && !rx_byte_valid && bit_tick &&
		(idle_bits >= timeout);
	// plain payload byte with room left
	assign store = (state == st_payload) && rx_byte_valid && !rx_byte_err &&
		!is_delim && !amp_seen && (cnt < msg_max_bytes);

	// idle gap measured in bit times since the last byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			idle_cyc  <= '0;
			idle_bits <= '0;
		end else if (state != st_payload || rx_byte_valid) begin
			idle_cyc  <= '0;
			idle_bits <= '0;
		end else if (bit_tick) begin
			idle_cyc  <= '0;
			idle_bits <= idle_bits + 16'd1;
		end else begin
			idle_cyc <= idle_cyc + 16'd1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= st_hunt;
			amp_seen   <= 1'b0;
			cnt        <= '0;
			frame_ok   <= 1'b0;
			frame_drop <= 1'b0;
		end else begin
			frame_ok   <= 1'b0;
			frame_drop <= 1'b0;
			case (state)
				st_hunt: if (rx_byte_valid) begin
					amp_seen <= !rx_byte_err && is_delim;
					if (!rx_byte_err && is_delim && amp_seen) begin
						state    <= st_payload;
						amp_seen <= 1'b0;
						cnt      <= '0;
					end
				end
				st_payload: begin
					if (timed_out) begin
						frame_drop <= 1'b1;
						state      <= st_hunt;
						amp_seen   <= 1'b0;
					end else if (rx_byte_valid) begin
						if (rx_byte_err || (amp_seen && !is_delim) ||
							(!is_delim && cnt == msg_max_bytes) ||
							(is_delim && amp_seen && cnt == '0)) begin
							frame_drop <= 1'b1;
							state      <= st_hunt;
							amp_seen   <= 1'b0;
						end else if (is_delim && amp_seen) begin
							frame_ok <= 1'b1;
							state    <= st_hold;
							amp_seen <= 1'b0;
						end else if (is_delim) begin
							amp_seen <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: if (rx_ready)
					state <= st_hunt;
			endcase
		end
	end

	// message buffer is cleared at each opening pair
	always_ff @(posedge sys_clk) begin
		if (state == st_hunt && rx_byte_valid && !rx_byte_err && is_delim && amp_seen) begin
			rx_msg <= '0;
		end else if (store) begin
			rx_msg.data[cnt[3:0]] <= rx_byte;
		end else if (state == st_payload && rx_byte_valid && is_delim && amp_seen) begin
			rx_msg.len <= cnt;
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_cfg_regs.sv
// configuration register block
// divisor and idle timeout registers, saturating frame counters, read-back mux
`timescale 1ns/10ps
`default_nettype none

module uart_cfg_regs #(
	parameter logic [15:0] default_div     = 16'd8,
	parameter logic [15:0] default_timeout = 16'd20
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   cfg_we,
	input  uart_frame_pkg::cfg_addr_t cfg_addr,
	input  logic [15:0]            cfg_wdata,
	output logic [15:0]            cfg_rdata,
	input  logic                   frame_ok,
	input  logic                   frame_drop,
	output logic [15:0]            divisor,
	output logic [15:0]            timeout
);
	import uart_frame_pkg::*;

	logic [15:0] frames_ok_cnt;
	logic [15:0] frames_drop_cnt;

	// writable registers, read-only addresses fall through
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			divisor <= default_div;
			timeout <= default_timeout;
		end else if (cfg_we) begin
			case (cfg_addr)
				reg_divisor: divisor <= (cfg_wdata < min_divisor) ? min_divisor : cfg_wdata;
				reg_timeout: timeout <= cfg_wdata;
				default: ;
			endcase
		end
	end

	// status counters stick at all ones
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frames_ok_cnt   <= '0;
			frames_drop_cnt <= '0;
		end else begin
			if (frame_ok && frames_ok_cnt != 16'hffff)
				frames_ok_cnt <= frames_ok_cnt + 16'd1;
			if (frame_drop && frames_drop_cnt != 16'hffff)
				frames_drop_cnt <= frames_drop_cnt + 16'd1;
		end
	end

	always_comb begin
		case (cfg_addr)
			reg_divisor:   cfg_rdata = divisor;
			reg_timeout:   cfg_rdata = timeout;
			reg_frames_ok: cfg_rdata = frames_ok_cnt;
			default:       cfg_rdata = frames_drop_cnt;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/uart_frame_pkg.sv
// shared types and constants for the "&&payload&&" UART framing subsystem
// message struct, configuration register map, delimiter and length limits
`default_nettype none

package uart_frame_pkg;

	// longest payload a frame may carry
	localparam int unsigned msg_max_bytes = 16;

	// length field wide enough for 0..msg_max_bytes
	localparam int unsigned len_w = 5;

	// delimiter byte, sent twice before and twice after the payload
	localparam logic [7:0] delim_char = 8'h26;

	// one whole message
	// data[0] goes out on the line first
	typedef struct packed {
		logic [len_w-1:0]              len;
		logic [msg_max_bytes-1:0][7:0] data;
	} frame_msg_t;

	// configuration register map
	typedef enum logic [1:0] {
		reg_divisor        = 2'd0,
		reg_timeout        = 2'd1,
		reg_frames_ok      = 2'd2,
		reg_frames_dropped = 2'd3
	} cfg_addr_t;

	// smallest divisor the byte engines accept
	localparam logic [15:0] min_divisor = 16'd4;

endpackage

`default_nettype wire

//--- rtl/uart_frame_top.sv
// framed UART subsystem top level
// register block, frame packer and unpacker, UART byte engines
`timescale 1ns/10ps
`default_nettype none

module uart_frame_top #(
	parameter logic [15:0] default_div     = 16'd8,
	parameter logic [15:0] default_timeout = 16'd20
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_msg_t tx_msg,
	input  logic                       tx_valid,
	output logic                       tx_ready,
	output uart_frame_pkg::frame_msg_t rx_msg,
	output logic                       rx_valid,
	input  logic                       rx_ready,
	input  logic                       cfg_we,
	input  uart_frame_pkg::cfg_addr_t  cfg_addr,
	input  logic [15:0]                cfg_wdata,
	output logic [15:0]                cfg_rdata,
	input  logic                       uart_rx_line,
	output logic                       uart_tx_line
);

	logic [15:0] divisor;
	logic [15:0] timeout;
	logic        frame_ok;
	logic        frame_drop;

	// packer to serializer
	logic [7:0]  tx_byte;
	logic        tx_byte_valid;
	logic        tx_byte_ready;

	// deserializer to unpacker, no back-pressure
	logic [7:0]  rx_byte;
	logic        rx_byte_valid;
	logic        rx_byte_err;

	uart_cfg_regs #(
		.default_div     (default_div),
		.default_timeout (default_timeout)
	) u_cfg_regs (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.frame_ok   (frame_ok),
		.frame_drop (frame_drop),
		.divisor    (divisor),
		.timeout    (timeout)
	);

	frame_packer u_packer (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.tx_msg        (tx_msg),
		.tx_valid      (tx_valid),
		.tx_ready      (tx_ready),
		.tx_byte       (tx_byte),
		.tx_byte_valid (tx_byte_valid),
		.tx_byte_ready (tx_byte_ready)
	);

	uart_tx u_uart_tx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.divisor       (divisor),
		.tx_byte       (tx_byte),
		.tx_byte_valid (tx_byte_valid),
		.tx_byte_ready (tx_byte_ready),
		.line          (uart_tx_line)
	);

	uart_rx u_uart_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.divisor       (divisor),
		.line          (uart_rx_line),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_byte_err   (rx_byte_err)
	);

	frame_unpacker u_unpacker (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_byte_err   (rx_byte_err),
		.divisor       (divisor),
		.timeout       (timeout),
		.rx_msg        (rx_msg),
		.rx_valid      (rx_valid),
		.rx_ready      (rx_ready),
		.frame_ok      (frame_ok),
		.frame_drop    (frame_drop)
	);

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
// UART byte deserializer, 8N1
// two-flop synchronizer, start-bit check at half a bit, mid-bit sampling,
// stop-bit error flag
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [15:0] divisor,
	input  logic        line,
	output logic [7:0]  rx_byte,
	output logic        rx_byte_valid,
	output logic        rx_byte_err
);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t   state;
	logic        line_meta;
	logic        line_sync;
	logic        line_prev;
	logic [15:0] baud_cnt;
	logic [2:0]  bit_cnt;
	logic        half_end;
	logic        bit_end;

	assign half_end = (baud_cnt == (divisor >> 1) - 16'd1);
	assign bit_end  = (baud_cnt == divisor - 16'd1);

	// line is asynchronous to sys_clk
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
			line_prev <= 1'b1;
		end else begin
			line_meta <= line;
			line_sync <= line_meta;
			line_prev <= line_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= st_idle;
			baud_cnt      <= '0;
			bit_cnt       <= '0;
			rx_byte_valid <= 1'b0;
			rx_byte_err   <= 1'b0;
		end else begin
			rx_byte_valid <= 1'b0;
			baud_cnt      <= baud_cnt + 16'd1;
			case (state)
				st_idle: begin
					baud_cnt <= '0;
					if (line_prev && !line_sync)
						state <= st_start;
				end
				st_start: if (half_end) begin
					// glitch shorter than half a bit is ignored
					baud_cnt <= '0;
					bit_cnt  <= '0;
					state    <= line_sync ? st_idle : st_data;
				end
				st_data: if (bit_end) begin
					baud_cnt <= '0;
					bit_cnt  <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= st_stop;
				end
				default: if (bit_end) begin
					// middle of the stop bit
					rx_byte_valid <= 1'b1;
					rx_byte_err   <= !line_sync;
					state         <= st_idle;
				end
			endcase
		end
	end

	// data shifts in lsb first at each data bit middle
	always_ff @(posedge sys_clk) begin
		if (state == st_data && bit_end)
			rx_byte <= {line_sync, rx_byte[7:1]};
	end

	a_valid_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte_valid |=> !rx_byte_valid
	);

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// UART byte serializer, 8N1
// own baud counter, valid/ready byte input, registered line output
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [15:0] divisor,
	input  logic [7:0]  tx_byte,
	input  logic        tx_byte_valid,
	output logic        tx_byte_ready,
	output logic        line
);

	logic        busy;
	logic [15:0] div_q;
	logic [15:0] baud_cnt;
	logic [3:0]  bit_cnt;
	// stop, data lsb first, start; bit 0 is on the line
	logic [9:0]  shift_q;
	logic        bit_end;

	assign tx_byte_ready = !busy;
	assign bit_end       = (baud_cnt == div_q - 16'd1);
	assign line          = shift_q[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			div_q    <= 16'd4;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			shift_q  <= '1;
		end else if (!busy) begin
			if (tx_byte_valid) begin
				// divisor held for the whole byte
				busy     <= 1'b1;
				div_q    <= divisor;
				baud_cnt <= '0;
				bit_cnt  <= '0;
				shift_q  <= {1'b1, tx_byte, 1'b0};
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			// ones shift in, so the line rests high afterwards
			shift_q  <= {1'b1, shift_q[9:1]};
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 4'd1;
		end else begin
			baud_cnt <= baud_cnt + 16'd1;
		end
	end

	// idle engine never leaves the line low
	a_idle_line_high: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_byte_ready |-> line
	);

endmodule

`default_nettype wire

//--- test/tb_uart_frame.sv
// directed testbench for the framed UART subsystem
// serial line model with a loopback switch, register access, message checks
`timescale 1ns/10ps
`default_nettype none

module tb_uart_frame;
	import uart_frame_pkg::*;

	localparam logic [15:0] div_reset     = 16'd8;
	localparam logic [15:0] timeout_reset = 16'd20;

	logic        sys_clk = 1'b0;
	logic        sys_rst_n;
	frame_msg_t  tx_msg;
	logic        tx_valid;
	logic        tx_ready;
	frame_msg_t  rx_msg;
	logic        rx_valid;
	logic        rx_ready;
	logic        cfg_we;
	cfg_addr_t   cfg_addr;
	logic [15:0] cfg_wdata;
	logic [15:0] cfg_rdata;
	logic        uart_rx_line;
	logic        uart_tx_line;

	// line model
	logic        loopback;
	logic        line_drv;
	int          cur_div;

	integer      seed;
	int          ok_exp;
	int          drop_exp;
	int          deliv_exp;
	int          deliveries = 0;

	assign uart_rx_line = loopback ? uart_tx_line : line_drv;

	uart_frame_top #(
		.default_div     (div_reset),
		.default_timeout (timeout_reset)
	) dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_valid     (tx_valid),
		.tx_ready     (tx_ready),
		.rx_msg       (rx_msg),
		.rx_valid     (rx_valid),
		.rx_ready     (rx_ready),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.uart_rx_line (uart_rx_line),
		.uart_tx_line (uart_tx_line)
	);

	always #5 sys_clk = ~sys_clk;

	// one count per rx_valid/rx_ready transfer
	always @(posedge sys_clk) begin
		if (rx_valid && rx_ready)
			deliveries <= deliveries + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		assert (got === exp) else
			abort_run($sformatf("FAIL at %0t ns: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	task automatic cfg_write(input cfg_addr_t a, input logic [15:0] d);
		@(posedge sys_clk);
		cfg_we    <= 1'b1;
		cfg_addr  <= a;
		cfg_wdata <= d;
		@(posedge sys_clk);
		cfg_we    <= 1'b0;
	endtask

	// read-back is combinational so it is sampled mid-cycle
	task automatic cfg_read(input cfg_addr_t a, output logic [15:0] d);
		@(posedge sys_clk);
		cfg_addr <= a;
		@(negedge sys_clk);
		d = cfg_rdata;
	endtask

	// start, 8 data bits lsb first, stop, one idle bit
	task automatic send_serial_byte(input logic [7:0] b, input logic stop_bit);
		logic [10:0] bits;
		bits = {1'b1, stop_bit, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge sys_clk);
			line_drv <= bits[i];
			repeat (cur_div - 1) @(posedge sys_clk);
		end
	endtask

	task automatic send_text(input string s);
		for (int i = 0; i < s.len(); i++)
			send_serial_byte(s[i], 1'b1);
	endtask

	task automatic wait_tx_ready();
		int n;
		n = 0;
		@(negedge sys_clk);
		while (!tx_ready && n < 400 * cur_div) begin
			@(negedge sys_clk);
			n++;
		end
		assert (tx_ready) else abort_run("timed out waiting for tx_ready");
	endtask

	task automatic wait_rx_valid();
		int n;
		n = 0;
		@(negedge sys_clk);
		while (!rx_valid && n < 400 * cur_div) begin
			@(negedge sys_clk);
			n++;
		end
		assert (rx_valid) else abort_run("timed out waiting for a received message");
	endtask

	task automatic send_msg(input frame_msg_t m);
		wait_tx_ready();
		@(posedge sys_clk);
		tx_msg   <= m;
		tx_valid <= 1'b1;
		@(posedge sys_clk);
		tx_valid <= 1'b0;
	endtask

	// payload bytes never equal the delimiter
	task automatic make_random_msg(input int n, output frame_msg_t m);
		logic [7:0] b;
		m     = '0;
		m.len = len_w'(n);
		for (int i = 0; i < n; i++) begin
			b = 8'($random(seed));
			if (b == delim_char)
				b = 8'h2a;
			m.data[i] = b;
		end
	endtask

	function automatic frame_msg_t text_msg(input string s);
		frame_msg_t m;
		m     = '0;
		m.len = len_w'(s.len());
		for (int i = 0; i < s.len(); i++)
			m.data[i] = s[i];
		return m;
	endfunction

	task automatic check_msg(input frame_msg_t got, input frame_msg_t exp);
		check_value(got.len, exp.len, "rx_msg.len");
		check_value(got.data, exp.data, "rx_msg.data");
	endtask

	task automatic check_counts();
		logic [15:0] d;
		cfg_read(reg_frames_ok, d);
		check_value(d, ok_exp, "frames_ok");
		cfg_read(reg_frames_dropped, d);
		check_value(d, drop_exp, "frames_dropped");
		check_value(deliveries, deliv_exp, "delivered message count");
	endtask

	// one cycle of rx_ready takes a held message
	task automatic release_msg();
		@(posedge sys_clk);
		rx_ready <= 1'b1;
		@(posedge sys_clk);
		rx_ready <= 1'b0;
		@(negedge sys_clk);
		check_value(rx_valid, 1'b0, "rx_valid after the message was taken");
		deliv_exp++;
	endtask

	task automatic loopback_one(input int n);
		frame_msg_t m;
		make_random_msg(n, m);
		send_msg(m);
		wait_rx_valid();
		check_msg(rx_msg, m);
		ok_exp++;
		deliv_exp++;
	endtask

	task automatic expect_drop();
		drop_exp++;
		check_value(rx_valid, 1'b0, "rx_valid after a dropped frame");
		check_counts();
	endtask

	task automatic test_reset_regs();
		logic [15:0] d;
		@(negedge sys_clk);
		check_value(tx_ready, 1'b1, "tx_ready after reset");
		check_value(rx_valid, 1'b0, "rx_valid after reset");
		check_value(uart_tx_line, 1'b1, "uart_tx_line after reset");
		cfg_read(reg_divisor, d);
		check_value(d, div_reset, "divisor reset value");
		cfg_read(reg_timeout, d);
		check_value(d, timeout_reset, "timeout reset value");
		cfg_write(reg_divisor, 16'd2);
		cfg_read(reg_divisor, d);
		check_value(d, 16'd4, "divisor written below the minimum");
		cfg_write(reg_divisor, div_reset);
		// read-only counter ignores writes
		cfg_write(reg_frames_ok, 16'h1234);
		cfg_read(reg_frames_ok, d);
		check_value(d, 16'd0, "frames_ok after a write");
	endtask

	task automatic test_loopback();
		@(posedge sys_clk);
		loopback <= 1'b1;
		loopback_one(1);
		loopback_one(5);
		loopback_one(16);
		check_counts();
	endtask

	task automatic test_backpressure();
		frame_msg_t m;
		@(posedge sys_clk);
		rx_ready <= 1'b0;
		make_random_msg(9, m);
		send_msg(m);
		wait_rx_valid();
		check_msg(rx_msg, m);
		ok_exp++;
		repeat (200) begin
			@(negedge sys_clk);
			check_value(rx_valid, 1'b1, "rx_valid while rx_ready is low");
			check_msg(rx_msg, m);
		end
		release_msg();
		check_counts();
		@(posedge sys_clk);
		rx_ready <= 1'b1;
		// slower line
		cfg_write(reg_divisor, 16'd16);
		cur_div = 16;
		loopback_one(7);
		check_counts();
	endtask

	task automatic test_line_framing();
		@(posedge sys_clk);
		loopback <= 1'b0;
		rx_ready <= 1'b0;
		cfg_write(reg_divisor, div_reset);
		cur_div = div_reset;
		// stray single delimiters before the real opening pair
		send_text("x&q&z");
		send_text("&&abc&&");
		wait_rx_valid();
		check_msg(rx_msg, text_msg("abc"));
		ok_exp++;
		release_msg();
		check_counts();
	endtask

	task automatic test_drops();
		send_text("&&abcdefghijklmnopq");
		expect_drop();
		send_text("&&a");
		send_serial_byte("b", 1'b0);
		expect_drop();
		send_text("&&ab");
		repeat ((timeout_reset + 10) * cur_div) @(posedge sys_clk);
		expect_drop();
		send_text("&&&&");
		expect_drop();
		send_text("&&ok&&");
		wait_rx_valid();
		check_msg(rx_msg, text_msg("ok"));
		ok_exp++;
		release_msg();
		check_counts();
	endtask

	initial begin
		seed      = 32'hf689ec8f;
		sys_rst_n = 1'b0;
		tx_msg    = '0;
		tx_valid  = 1'b0;
		rx_ready  = 1'b1;
		cfg_we    = 1'b0;
		cfg_addr  = reg_divisor;
		cfg_wdata = '0;
		loopback  = 1'b0;
		line_drv  = 1'b1;
		cur_div   = div_reset;
		ok_exp    = 0;
		drop_exp  = 0;
		deliv_exp = 0;
		repeat (2) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		test_reset_regs();
		test_loopback();
		test_backpressure();
		test_line_framing();
		test_drops();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/uart_frame_pkg.sv
rtl/uart_cfg_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/frame_packer.sv
rtl/frame_unpacker.sv
rtl/uart_frame_top.sv
test/tb_uart_frame.sv
